//--- filelist.f
hw/neoVideoPkg.sv
hw/sysLatch.sv
hw/pixelClockGen.sv
hw/paletteRam.sv
hw/colorConvert.sv
hw/videoOutTop.sv
test/videoOutTb.sv

//--- hw/colorConvert.sv
// Palette word to RGB888 with dark bit and shadow halving
// Colour and vBlank register on pixelEn; hBlank has one extra pixel stage
// Inputs are sampled in the cycle where pixelEn is high

module colorConvert (
	input  logic                     CLK_48M,
	input  logic                     nRESET,
	input  logic                     pixelEn,
	input  neoVideoPkg::palWord_t    palWord,
	input  logic                     shadow,
	input  logic                     hBlankIn,
	input  logic                     vBlankIn,
	output neoVideoPkg::colorChan_t  red,
	output neoVideoPkg::colorChan_t  green,
	output neoVideoPkg::colorChan_t  blue,
	output logic                     hBlank,
	output logic                     vBlank
);

	// 6-bit intensity is field, low-order bit, field MSB
	// Dark subtracts one, underflow clamps to black
	function automatic neoVideoPkg::colorChan_t expandChan(
		input logic [3:0] field,
		input logic       lowBit,
		input logic       dark
	);
		logic [6:0] level;
		level = {1'b0, field, lowBit, field[3]} - {6'd0, dark};
		return level[6] ? '0 : {level[5:0], level[4:3]};
	endfunction

	// Shadow halves the channel
	function automatic neoVideoPkg::colorChan_t shade(
		input neoVideoPkg::colorChan_t chan,
		input logic                    halve
	);
		return halve ? {1'b0, chan[7:1]} : chan;
	endfunction

	neoVideoPkg::colorChan_t red8;
	neoVideoPkg::colorChan_t green8;
	neoVideoPkg::colorChan_t blue8;
	logic hBlankDly;

	assign red8   = expandChan(palWord[11:8], palWord[14], palWord[15]);
	assign green8 = expandChan(palWord[7:4], palWord[13], palWord[15]);
	assign blue8  = expandChan(palWord[3:0], palWord[12], palWord[15]);

	// ==============================
	// Output registers
	// ==============================

	always_ff @(posedge CLK_48M) begin
		if (!nRESET) begin
			red       <= '0;
			green     <= '0;
			blue      <= '0;
			hBlankDly <= 1'b0;
			hBlank    <= 1'b0;
			vBlank    <= 1'b0;
		end else if (pixelEn) begin
			red       <= shade(red8, shadow);
			green     <= shade(green8, shadow);
			blue      <= shade(blue8, shadow);
			// Two pixel stages for horizontal blanking
			hBlankDly <= hBlankIn;
			hBlank    <= hBlankDly;
			vBlank    <= vBlankIn;
		end
	end

endmodule

//--- hw/neoVideoPkg.sv
// Shared widths and types for the colour output stage
// The palette word layout follows the original hardware format
// Latch slots other than shadow and palette bank have no function here

package neoVideoPkg;

	// ==============================
	// Widths
	// ==============================

	// One palette colour word as stored in palette RAM
	localparam int PAL_WORD_W = 16;

	// One output colour channel, RGB888
	localparam int COLOR_W = 8;

	// ==============================
	// Types
	// ==============================

	// Bit 15 dark, bits 14..12 low-order R/G/B,
	// then 4-bit red, green and blue at 11:8, 7:4, 3:0
	typedef logic [PAL_WORD_W-1:0] palWord_t;

	typedef logic [COLOR_W-1:0] colorChan_t;

	// System latch slot, taken from the upper latch address bits
	// Only two slots are kept, the rest fall through
	typedef enum logic [2:0] {
		SHADOW   = 3'd0,
		PAL_BANK = 3'd7
	} latchSel_t;

endpackage

//--- hw/paletteRam.sv
// Two-bank palette RAM, one CPU write port and one registered pixel read port
// palBank selects the bank for both ports at the time of access
// Contents are not cleared by reset

module paletteRam #(
	parameter int PAL_ADDR_W = 12
) (
	input  logic                  CLK_48M,
	input  logic                  palWr,
	input  logic [PAL_ADDR_W-1:0] palAddr,
	input  neoVideoPkg::palWord_t palData,
	input  logic                  palBank,
	input  logic [PAL_ADDR_W-1:0] palIndex,
	output neoVideoPkg::palWord_t palWord
);

	localparam int DEPTH = 2 ** (PAL_ADDR_W + 1);

	neoVideoPkg::palWord_t mem [DEPTH];

	logic [PAL_ADDR_W:0] wrAddr;
	logic [PAL_ADDR_W:0] rdAddr;

	// Bank bit on top of the index
	assign wrAddr = {palBank, palAddr};
	assign rdAddr = {palBank, palIndex};

	// ==============================
	// CPU write port
	// ==============================

	always_ff @(posedge CLK_48M) begin
		if (palWr) begin
			mem[wrAddr] <= palData;
		end
	end

	// ==============================
	// Pixel read port
	// ==============================

	// Sees a CPU write from the following cycle on
	always_ff @(posedge CLK_48M) begin
		palWord <= mem[rdAddr];
	end

endmodule

//--- hw/pixelClockGen.sv
// Pixel clock enable from CLK_48M
// One-cycle pulse every PIXEL_DIV cycles, first pulse PIXEL_DIV cycles
// after reset is released

module pixelClockGen #(
	parameter int PIXEL_DIV = 8
) (
	input  logic CLK_48M,
	input  logic nRESET,
	output logic pixelEn
);

	localparam int CNT_W = (PIXEL_DIV > 1) ? $clog2(PIXEL_DIV) : 1;

	logic [CNT_W-1:0] divCnt;

	// Wrapping divider, pulse registered on the wrap
	always_ff @(posedge CLK_48M) begin
		if (!nRESET) begin
			divCnt  <= '0;
			pixelEn <= 1'b0;
		end else if (divCnt == CNT_W'(PIXEL_DIV - 1)) begin
			divCnt  <= '0;
			pixelEn <= 1'b1;
		end else begin
			divCnt  <= divCnt + 1'b1;
			pixelEn <= 1'b0;
		end
	end

endmodule

//--- hw/sysLatch.sv
// System latch holding the shadow bit and the palette bank select
// latchAddr[3:1] picks the slot, latchAddr[0] is the value written
// Unknown slots are ignored; outputs update one cycle after the strobe

module sysLatch (
	input  logic       CLK_48M,
	input  logic       nRESET,
	input  logic       latchWr,
	input  logic [3:0] latchAddr,
	output logic       shadow,
	output logic       palBank
);

	neoVideoPkg::latchSel_t slot;
	logic value;

	// Slot code and data bit of the current write
	assign slot  = neoVideoPkg::latchSel_t'(latchAddr[3:1]);
	assign value = latchAddr[0];

	// ==============================
	// Latch registers
	// ==============================

	always_ff @(posedge CLK_48M) begin
		if (!nRESET) begin
			shadow  <= 1'b0;
			palBank <= 1'b0;
		end else if (latchWr) begin
			case (slot)
				neoVideoPkg::SHADOW: begin
					shadow <= value;
				end
				neoVideoPkg::PAL_BANK: begin
					palBank <= value;
				end
				default: begin
					// Slot not kept in this design
				end
			endcase
		end
	end

endmodule

//--- hw/videoOutTop.sv
// Colour output stage: palette RAM, system latch, pixel enable, RGB conversion
// Pixel inputs must be held for a full pixel period; no back-pressure
// An index held two cycles before a pixel enable shows on RGB after it

module videoOutTop #(
	parameter int PAL_ADDR_W = 12,
	parameter int PIXEL_DIV  = 8
) (
	input  logic                    CLK_48M,
	input  logic                    nRESET,
	input  logic                    palWr,
	input  logic [PAL_ADDR_W-1:0]   palAddr,
	input  neoVideoPkg::palWord_t   palData,
	input  logic                    latchWr,
	input  logic [3:0]              latchAddr,
	input  logic [PAL_ADDR_W-1:0]   palIndex,
	input  logic                    hBlankIn,
	input  logic                    vBlankIn,
	output neoVideoPkg::colorChan_t red,
	output neoVideoPkg::colorChan_t green,
	output neoVideoPkg::colorChan_t blue,
	output logic                    hBlank,
	output logic                    vBlank,
	output logic                    cePixel
);

	logic shadow;
	logic palBank;
	logic pixelEn;
	neoVideoPkg::palWord_t palWord;

	// ==============================
	// Control
	// ==============================

	sysLatch latchInst (
		.CLK_48M   (CLK_48M),
		.nRESET    (nRESET),
		.latchWr   (latchWr),
		.latchAddr (latchAddr),
		.shadow    (shadow),
		.palBank   (palBank)
	);

	pixelClockGen #(.PIXEL_DIV(PIXEL_DIV)) pixClkInst (
		.CLK_48M (CLK_48M),
		.nRESET  (nRESET),
		.pixelEn (pixelEn)
	);

	// ==============================
	// Datapath
	// ==============================

	paletteRam #(.PAL_ADDR_W(PAL_ADDR_W)) palRamInst (
		.CLK_48M  (CLK_48M),
		.palWr    (palWr),
		.palAddr  (palAddr),
		.palData  (palData),
		.palBank  (palBank),
		.palIndex (palIndex),
		.palWord  (palWord)
	);

	colorConvert convInst (
		.CLK_48M  (CLK_48M),
		.nRESET   (nRESET),
		.pixelEn  (pixelEn),
		.palWord  (palWord),
		.shadow   (shadow),
		.hBlankIn (hBlankIn),
		.vBlankIn (vBlankIn),
		.red      (red),
		.green    (green),
		.blue     (blue),
		.hBlank   (hBlank),
		.vBlank   (vBlank)
	);

	// Video sink samples on the same enable
	assign cePixel = pixelEn;

endmodule

//--- run.sh
#!/bin/sh
# Compile and run the colour output stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
	echo "verilator not found in PATH"
	exit 1
fi

if ! verilator --binary --timing -f filelist.f --top-module videoOutTb \
	-Mdir obj_dir -o videoOutSim; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/videoOutSim 2>&1)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test passed"; then
	exit 0
else
	echo "Pass message not found in simulation output"
	exit 1
fi

//--- test/videoOutTb.sv
// Testbench for the colour output stage, default parameters (12-bit index, divide by 8)
// Inputs are driven on the rising edge and outputs sampled on the falling edge
// Expected colours come from a separate integer model of the palette format

module videoOutTb;

	localparam int PIXEL_DIV = 8;
	localparam int N_ENTRIES = 12;
	localparam int N_FIXED   = 5;
	localparam int MARGIN    = 1000;

	// Fixed corner cases at the head of the table
	localparam logic [11:0] FIX_IDX [N_FIXED] =
		'{12'h000, 12'h001, 12'h002, 12'hFFF, 12'h010};
	localparam logic [15:0] FIX_WORD [N_FIXED] =
		'{16'h0000, 16'h7FFF, 16'h8000, 16'hFFFF, 16'h0F00};
	localparam logic FIX_SHADOW [N_FIXED] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
	localparam logic FIX_BANK   [N_FIXED] = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b0};

	logic                    CLK_48M;
	logic                    nRESET;
	logic                    palWr;
	logic [11:0]             palAddr;
	neoVideoPkg::palWord_t   palData;
	logic                    latchWr;
	logic [3:0]              latchAddr;
	logic [11:0]             palIndex;
	logic                    hBlankIn;
	logic                    vBlankIn;
	neoVideoPkg::colorChan_t red;
	neoVideoPkg::colorChan_t green;
	neoVideoPkg::colorChan_t blue;
	logic                    hBlank;
	logic                    vBlank;
	logic                    cePixel;

	// Stimulus table: index, word, shadow, bank
	logic [11:0]           tIdx    [N_ENTRIES];
	neoVideoPkg::palWord_t tWord   [N_ENTRIES];
	logic                  tShadow [N_ENTRIES];
	logic                  tBank   [N_ENTRIES];

	int errors;
	int checks;
	int seed;

	videoOutTop uut (
		.CLK_48M   (CLK_48M),
		.nRESET    (nRESET),
		.palWr     (palWr),
		.palAddr   (palAddr),
		.palData   (palData),
		.latchWr   (latchWr),
		.latchAddr (latchAddr),
		.palIndex  (palIndex),
		.hBlankIn  (hBlankIn),
		.vBlankIn  (vBlankIn),
		.red       (red),
		.green     (green),
		.blue      (blue),
		.hBlank    (hBlank),
		.vBlank    (vBlank),
		.cePixel   (cePixel)
	);

	initial begin
		CLK_48M = 1'b0;
		forever #5 CLK_48M = ~CLK_48M;
	end

	// ==============================
	// Reference model and checks
	// ==============================

	// Intensity = field*4 + low bit*2 + field MSB, minus dark; 8 bits = level*4 + level[4:3]
	function automatic int modelChan(input int field, input int lowBit, input int dark,
		input int halve);
		int level;
		int chan;
		level = field * 4 + lowBit * 2 + field / 8 - dark;
		if (level < 0) begin
			chan = 0;
		end else begin
			chan = level * 4 + (level / 8) % 4;
		end
		if (halve != 0) begin
			chan = chan / 2;
		end
		return chan;
	endfunction

	task automatic checkVal(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAILED time=%0t signal=%s expected=%0h actual=%0h",
				$time, name, expected, actual);
		end
	endtask

	task automatic checkColor(input neoVideoPkg::palWord_t word, input logic halve);
		checkVal("red", modelChan(int'(word[11:8]), int'(word[14]), int'(word[15]),
			int'(halve)), red);
		checkVal("green", modelChan(int'(word[7:4]), int'(word[13]), int'(word[15]),
			int'(halve)), green);
		checkVal("blue", modelChan(int'(word[3:0]), int'(word[12]), int'(word[15]),
			int'(halve)), blue);
	endtask

	// ==============================
	// Bus and timing helpers
	// ==============================

	task automatic latchWrite(input logic [2:0] slot, input logic val);
		@(posedge CLK_48M);
		latchWr   <= 1'b1;
		latchAddr <= {slot, val};
		@(posedge CLK_48M);
		latchWr   <= 1'b0;
	endtask

	task automatic palWrite(input logic [11:0] idx, input neoVideoPkg::palWord_t word);
		@(posedge CLK_48M);
		palWr   <= 1'b1;
		palAddr <= idx;
		palData <= word;
		@(posedge CLK_48M);
		palWr   <= 1'b0;
	endtask

	// Returns on the falling edge after the enable has been taken
	task automatic waitPixels(input int count);
		int n;
		for (int i = 0; i < count; i++) begin
			n = 0;
			do begin
				@(negedge CLK_48M);
				n++;
			end while (!cePixel && n < 4 * PIXEL_DIV);
			if (!cePixel) begin
				errors++;
				$display("ERROR time=%0t no pixel enable seen within %0d cycles",
					$time, 4 * PIXEL_DIV);
			end
			@(negedge CLK_48M);
		end
	endtask

	task automatic showIndex(input logic [11:0] idx);
		@(posedge CLK_48M);
		palIndex <= idx;
		waitPixels(2);
	endtask

	// ==============================
	// Watchdog
	// ==============================

	initial begin
		repeat (N_ENTRIES * 40 + MARGIN) @(posedge CLK_48M);
		$display("ERROR run timed out after %0d cycles", N_ENTRIES * 40 + MARGIN);
		$display("Test failed");
		$finish;
	end

	// ==============================
	// Main sequence
	// ==============================

	initial begin
		logic [31:0] rnd;
		int cycles;
		neoVideoPkg::palWord_t w;
		errors = 0;
		checks = 0;
		seed = 32'ha8415637;
		nRESET    <= 1'b0;
		palWr     <= 1'b0;
		palAddr   <= '0;
		palData   <= '0;
		latchWr   <= 1'b0;
		latchAddr <= '0;
		palIndex  <= '0;
		hBlankIn  <= 1'b0;
		vBlankIn  <= 1'b0;

		// Fixed corner cases, random words after
		for (int i = 0; i < N_FIXED; i++) begin
			tIdx[i]    = FIX_IDX[i];
			tWord[i]   = FIX_WORD[i];
			tShadow[i] = FIX_SHADOW[i];
			tBank[i]   = FIX_BANK[i];
		end
		for (int i = N_FIXED; i < N_ENTRIES; i++) begin
			rnd = $random(seed);
			tIdx[i]    = rnd[11:0];
			tShadow[i] = rnd[12];
			tBank[i]   = rnd[13];
			rnd = $random(seed);
			tWord[i]   = rnd[15:0];
		end

		repeat (2) @(posedge CLK_48M);
		nRESET <= 1'b1;

		// Reset state
		@(negedge CLK_48M);
		checkVal("red", 0, red);
		checkVal("green", 0, green);
		checkVal("blue", 0, blue);
		checkVal("hBlank", 0, hBlank);
		checkVal("vBlank", 0, vBlank);
		checkVal("cePixel", 0, cePixel);

		// Pixel enable period, first count starts one cycle past a pulse
		waitPixels(1);
		cycles = 1;
		for (int p = 0; p < 3; p++) begin
			do begin
				@(negedge CLK_48M);
				cycles++;
			end while (!cePixel && cycles < 4 * PIXEL_DIV);
			checkVal("cePixel period", PIXEL_DIV, cycles);
			cycles = 0;
		end

		// Table-driven colour conversion
		for (int i = 0; i < N_ENTRIES; i++) begin
			latchWrite(neoVideoPkg::SHADOW, tShadow[i]);
			latchWrite(neoVideoPkg::PAL_BANK, tBank[i]);
			palWrite(tIdx[i], tWord[i]);
			showIndex(tIdx[i]);
			checkColor(tWord[i], tShadow[i]);
		end

		// Shadow on, off, and writes to unused slots
		rnd = $random(seed);
		w = rnd[15:0];
		latchWrite(neoVideoPkg::PAL_BANK, 1'b0);
		latchWrite(neoVideoPkg::SHADOW, 1'b1);
		palWrite(12'h055, w);
		showIndex(12'h055);
		checkColor(w, 1'b1);
		latchWrite(neoVideoPkg::SHADOW, 1'b0);
		waitPixels(2);
		checkColor(w, 1'b0);
		for (int s = 1; s < 7; s++) begin
			latchWrite(3'(s), 1'b1);
		end
		waitPixels(2);
		checkColor(w, 1'b0);

		// Same index in both banks
		latchWrite(neoVideoPkg::PAL_BANK, 1'b0);
		palWrite(12'h123, 16'h0F0F);
		latchWrite(neoVideoPkg::PAL_BANK, 1'b1);
		palWrite(12'h123, 16'h70F0);
		showIndex(12'h123);
		checkColor(16'h70F0, 1'b0);
		latchWrite(neoVideoPkg::PAL_BANK, 1'b0);
		waitPixels(2);
		checkColor(16'h0F0F, 1'b0);
		latchWrite(neoVideoPkg::PAL_BANK, 1'b1);
		waitPixels(2);
		checkColor(16'h70F0, 1'b0);

		// Blanking delays, one stage for vBlank and two for hBlank
		waitPixels(1);
		@(posedge CLK_48M);
		hBlankIn <= 1'b1;
		vBlankIn <= 1'b1;
		@(negedge CLK_48M);
		checkVal("vBlank", 0, vBlank);
		waitPixels(1);
		checkVal("vBlank", 1, vBlank);
		checkVal("hBlank", 0, hBlank);
		waitPixels(1);
		checkVal("hBlank", 1, hBlank);
		@(posedge CLK_48M);
		hBlankIn <= 1'b0;
		vBlankIn <= 1'b0;
		waitPixels(1);
		checkVal("vBlank", 0, vBlank);
		checkVal("hBlank", 1, hBlank);
		waitPixels(1);
		checkVal("hBlank", 0, hBlank);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
